/* logic/icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// base geometry
`define ICACHE_WAY_BITS     3
`define ICACHE_INDEX_BITS   2
`define ICACHE_OFFSET_BITS  2
`define ICACHE_ALIGN_BITS   3
`define ICACHE_ADDR_BITS    32
`define ICACHE_CBUS_BYTES   4

// derived widths
`define ICACHE_NUM_WAYS     (2 ** `ICACHE_WAY_BITS)
`define ICACHE_NUM_SETS     (2 ** `ICACHE_INDEX_BITS)
`define ICACHE_DATA_BYTES   (2 ** `ICACHE_ALIGN_BITS)
`define ICACHE_DATA_BITS    (8 * `ICACHE_DATA_BYTES)
`define ICACHE_CBUS_BITS    (8 * `ICACHE_CBUS_BYTES)
`define ICACHE_SHAMT_BITS   (`ICACHE_ALIGN_BITS - $clog2(`ICACHE_CBUS_BYTES))
`define ICACHE_NONTAG_BITS  (`ICACHE_INDEX_BITS + `ICACHE_OFFSET_BITS + `ICACHE_ALIGN_BITS)
`define ICACHE_TAG_BITS     (`ICACHE_ADDR_BITS - `ICACHE_NONTAG_BITS)
`define ICACHE_COUNT_BITS   (`ICACHE_OFFSET_BITS + `ICACHE_SHAMT_BITS)
`define ICACHE_RAM_ADDR_BITS (`ICACHE_WAY_BITS + `ICACHE_INDEX_BITS + `ICACHE_OFFSET_BITS)
`define ICACHE_RAM_DEPTH    (2 ** `ICACHE_RAM_ADDR_BITS)

`endif

/* logic/icache_pkg.sv */
`include "icache_defines.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_BITS-1:0]    tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0]  index_t;
    typedef logic [`ICACHE_OFFSET_BITS-1:0] offset_t;
    typedef logic [`ICACHE_SHAMT_BITS-1:0]  shamt_t;
    typedef logic [`ICACHE_WAY_BITS-1:0]    way_t;
    typedef logic [`ICACHE_DATA_BITS-1:0]   data_t;
    typedef logic [`ICACHE_DATA_BYTES-1:0]  strobe_t;
    typedef logic [`ICACHE_CBUS_BITS-1:0]   cbus_data_t;

    // one bit per inner node of the way tree
    typedef logic [`ICACHE_NUM_WAYS-2:0] select_t;

    // byte address as seen by the fetch port
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        shamt_t     shamt;
        logic [1:0] zeros;
    } addr_t;

    // position of a word in the data RAM
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } iaddr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } line_t;

    // beat number within a line
    typedef struct packed {
        offset_t offset;
        shamt_t  shamt;
    } count_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic   addr_ok;
        logic   data_ok;
        data_t  data;
        shamt_t index;
    } ibus_resp_t;

    typedef struct packed {
        logic                         valid;
        logic                         is_write;
        logic [`ICACHE_ADDR_BITS-1:0] addr;
        logic [2:0]                   order;
        cbus_data_t                   wdata;
    } cbus_req_t;

    typedef struct packed {
        logic       okay;
        logic       last;
        cbus_data_t rdata;
    } cbus_resp_t;

endpackage

/* logic/icache_plru.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_plru import icache_pkg::*; (
    input  select_t select,
    input  way_t    hit_way,
    output way_t    victim,
    output select_t new_select
);

    // tree nodes kept heap style with children of n at 2n+1 and 2n+2
    // a zero bit points to the lower half

    always_comb begin
        int walk;
        walk = 0;
        victim = '0;
        for (int lvl = 0; lvl < `ICACHE_WAY_BITS; lvl++) begin
            // way number is built msb first from the root
            victim[`ICACHE_WAY_BITS-1-lvl] = select[walk];
            walk = 2 * walk + 1 + int'(select[walk]);
        end
    end

    always_comb begin
        int path;
        logic dir;
        new_select = select;
        path = 0;
        for (int lvl = 0; lvl < `ICACHE_WAY_BITS; lvl++) begin
            dir = hit_way[`ICACHE_WAY_BITS-1-lvl];
            // point each node on the path to the other subtree
            new_select[path] = ~dir;
            path = 2 * path + 1 + int'(dir);
        end
    end

endmodule

/* logic/icache_data_ram.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_ram import icache_pkg::*; (
    input  logic    clk,
    input  iaddr_t  rd_pos,
    output data_t   rd_data,
    input  strobe_t wr_en,
    input  iaddr_t  wr_pos,
    input  data_t   wr_data
);

    data_t mem [`ICACHE_RAM_DEPTH];

    // registered read port
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_pos];
    end

    // refill port with byte strobes
    always_ff @(posedge clk) begin
        for (int b = 0; b < `ICACHE_DATA_BYTES; b++) begin
            if (wr_en[b]) begin
                mem[wr_pos][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
    end

endmodule

/* logic/icache_tag_array.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tag_array import icache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  addr_t   lookup_addr,
    output logic    hit,
    output way_t    hit_way,
    output select_t select,
    input  logic    hit_update,
    input  select_t new_select,
    input  logic    alloc,
    input  way_t    alloc_way
);

    line_t   lines [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    select_t selects [`ICACHE_NUM_SETS];

    logic [`ICACHE_NUM_WAYS-1:0] hit_bits;
    index_t                      idx;

    assign idx = lookup_addr.index;

    // compare every way of the indexed set
    always_comb begin
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            hit_bits[w] = lines[idx][w].valid && (lines[idx][w].tag == lookup_addr.tag);
        end
    end

    assign hit = |hit_bits;

    // one-hot to binary encode of the matching way
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (hit_bits[w]) begin
                hit_way = hit_way | way_t'(w);
            end
        end
    end

    assign select = selects[idx];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
                selects[s] <= '0;
                for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
                    lines[s][w].valid <= 1'b0;
                end
            end
        end else begin
            if (hit_update) begin
                selects[idx] <= new_select;
            end
            // victim line is claimed as soon as the miss starts
            if (alloc) begin
                lines[idx][alloc_way] <= line_t'{valid: 1'b1, tag: lookup_addr.tag};
            end
        end
    end

endmodule

/* logic/icache_refill.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_refill import icache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  addr_t      start_addr,
    input  way_t       victim,
    input  iaddr_t     lookup_pos,
    input  shamt_t     lookup_half,
    output logic       line_busy,
    output logic       beat_ready,
    output logic       free,
    output strobe_t    wr_en,
    output iaddr_t     wr_pos,
    output data_t      wr_data,
    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);

    localparam int      ratio     = `ICACHE_DATA_BYTES / `ICACHE_CBUS_BYTES;
    localparam strobe_t beat_mask = strobe_t'({`ICACHE_CBUS_BYTES{1'b1}});

    logic   busy;
    addr_t  miss_addr;
    way_t   miss_way;
    count_t count;
    logic [2**`ICACHE_COUNT_BITS-1:0] ready;

    logic   beat;
    count_t lookup_count;
    addr_t  line_addr;

    assign beat = busy && cbus_resp.okay;

    // free now or after this edge
    assign free = !busy || (beat && cbus_resp.last);

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy <= 1'b0;
        end else if (free) begin
            busy <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            miss_addr    <= start_addr;
            miss_way     <= victim;
            // requested beat comes first
            count.offset <= start_addr.offset;
            count.shamt  <= start_addr.shamt;
            ready        <= '0;
        end else if (beat) begin
            ready[count] <= 1'b1;
            count        <= count_t'(count + 1'b1);
        end
    end

    // RAM write side
    assign wr_pos.way    = miss_way;
    assign wr_pos.index  = miss_addr.index;
    assign wr_pos.offset = count.offset;
    assign wr_data       = {ratio{cbus_resp.rdata}};
    assign wr_en         = beat ? strobe_t'(beat_mask << (count.shamt * `ICACHE_CBUS_BYTES))
                                : '0;

    // does the fetch land on the line in flight, and is its beat there
    assign lookup_count.offset = lookup_pos.offset;
    assign lookup_count.shamt  = lookup_half;

    assign line_busy  = busy && (lookup_pos.way == miss_way) &&
                        (lookup_pos.index == miss_addr.index);
    assign beat_ready = ready[lookup_count];

    always_comb begin
        line_addr          = miss_addr;
        line_addr.zeros    = '0;
        cbus_req.valid     = busy;
        cbus_req.is_write  = 1'b0;
        cbus_req.addr      = line_addr;
        // log2 of the beats in one line
        cbus_req.order     = 3'(`ICACHE_COUNT_BITS);
        cbus_req.wdata     = '0;
    end

endmodule

/* logic/icache.sv */
`timescale 1ns/1ps

module icache import icache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  ibus_req_t  ibus_req,
    output ibus_resp_t ibus_resp,
    input  cbus_resp_t cbus_resp,
    output cbus_req_t  cbus_req
);

    addr_t   req_addr;
    logic    req_hit;
    way_t    req_way;
    select_t req_select;
    select_t req_new_select;
    way_t    req_victim;
    iaddr_t  req_pos;

    logic    line_busy;
    logic    beat_ready;
    logic    refill_free;
    logic    req_ready;
    logic    to_hit;
    logic    to_miss;

    strobe_t ram_wr_en;
    iaddr_t  ram_wr_pos;
    data_t   ram_wr_data;
    data_t   ram_rd_data;

    logic    data_ok;
    shamt_t  resp_half;

    assign req_addr = ibus_req.addr;

    icache_tag_array tags (
        .clk        (clk),
        .resetn     (resetn),
        .lookup_addr(req_addr),
        .hit        (req_hit),
        .hit_way    (req_way),
        .select     (req_select),
        .hit_update (to_hit),
        .new_select (req_new_select),
        .alloc      (to_miss),
        .alloc_way  (req_victim)
    );

    icache_plru plru (
        .select    (req_select),
        .hit_way   (req_way),
        .victim    (req_victim),
        .new_select(req_new_select)
    );

    assign req_pos.way    = req_way;
    assign req_pos.index  = req_addr.index;
    assign req_pos.offset = req_addr.offset;

    icache_refill refill (
        .clk        (clk),
        .resetn     (resetn),
        .start      (to_miss),
        .start_addr (req_addr),
        .victim     (req_victim),
        .lookup_pos (req_pos),
        .lookup_half(req_addr.shamt),
        .line_busy  (line_busy),
        .beat_ready (beat_ready),
        .free       (refill_free),
        .wr_en      (ram_wr_en),
        .wr_pos     (ram_wr_pos),
        .wr_data    (ram_wr_data),
        .cbus_req   (cbus_req),
        .cbus_resp  (cbus_resp)
    );

    icache_data_ram ram (
        .clk    (clk),
        .rd_pos (req_pos),
        .rd_data(ram_rd_data),
        .wr_en  (ram_wr_en),
        .wr_pos (ram_wr_pos),
        .wr_data(ram_wr_data)
    );

    // a line under refill only serves beats already written
    assign req_ready = req_hit && (!line_busy || beat_ready);
    assign to_hit    = ibus_req.req && req_ready;
    assign to_miss   = ibus_req.req && !req_hit && refill_free;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= to_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (to_hit) begin
            resp_half <= req_addr.shamt;
        end
    end

    assign ibus_resp.addr_ok = req_ready;
    assign ibus_resp.data_ok = data_ok;
    assign ibus_resp.data    = ram_rd_data;
    assign ibus_resp.index   = resp_half;

endmodule

/* sim/mem_model.sv */
`timescale 1ns/1ps

module mem_model import icache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  cbus_req_t  cbus_req,
    output cbus_resp_t cbus_resp
);

    integer seed = 47987;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        return {a[23:0], a[31:24]} ^ 32'h3c5a_96e1;
    endfunction

    initial begin
        logic [31:0] base;
        logic [2:0]  pos;
        int          stall;
        int          beat;
        cbus_resp = '0;
        forever begin
            @(posedge clk);
            #10;
            cbus_resp = '0;
            if (!resetn && cbus_req.valid) begin
                base = cbus_req.addr;
                pos  = base[4:2];
                beat = 0;
                while (beat < 8 && !resetn) begin
                    stall = $unsigned($random(seed)) % 4;
                    while (stall > 0 && !resetn) begin
                        @(posedge clk);
                        #10;
                        stall--;
                    end
                    if (!resetn) begin
                        // wrap within the 32-byte line
                        cbus_resp.okay  = 1'b1;
                        cbus_resp.last  = (beat == 7);
                        cbus_resp.rdata = word_at({base[31:5], pos, 2'b00});
                        @(posedge clk);
                        #10;
                        cbus_resp = '0;
                        pos = pos + 3'd1;
                        beat++;
                    end
                end
            end
        end
    end

endmodule

/* sim/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache import icache_pkg::*;;

    logic       clk;
    logic       resetn;
    ibus_req_t  ibus_req;
    ibus_resp_t ibus_resp;
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;

    int errors = 0;
    int issued = 0;
    int cycle  = 0;

    // acceptance seen at the previous edge and its expected response
    logic        acc_q = 1'b0;
    logic [63:0] exp_q;
    logic [63:0] mask_q;
    logic        half_q;
    logic        rst_q = 1'b1;

    icache dut0 (
        .clk      (clk),
        .resetn   (resetn),
        .ibus_req (ibus_req),
        .ibus_resp(ibus_resp),
        .cbus_resp(cbus_resp),
        .cbus_req (cbus_req)
    );

    mem_model mem (
        .clk      (clk),
        .resetn   (resetn),
        .cbus_req (cbus_req),
        .cbus_resp(cbus_resp)
    );

    function automatic logic [31:0] word_at(input logic [31:0] a);
        return {a[23:0], a[31:24]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [63:0] expected_data(input logic [31:0] a);
        logic [31:0] base;
        base = {a[31:3], 3'b000};
        return {word_at(base + 32'd4), word_at(base)};
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle  <= cycle + 1;
        rst_q  <= resetn;
        acc_q  <= !resetn && ibus_req.req && ibus_resp.addr_ok;
        exp_q  <= expected_data(ibus_req.addr);
        half_q <= ibus_req.addr[2];
        // only the requested half is sure to be written while a refill runs
        if (cbus_req.valid) begin
            mask_q <= ibus_req.addr[2] ? 64'hffff_ffff_0000_0000 : 64'h0000_0000_ffff_ffff;
        end else begin
            mask_q <= '1;
        end
    end

    // data_ok follows each acceptance by one cycle and never appears otherwise
    a_data_ok: assert property (@(posedge clk) disable iff (resetn)
        ibus_resp.data_ok == acc_q)
        else begin
            errors++;
            $display("** Error: ibus_resp.data_ok = %h, expected %h",
                     $sampled(ibus_resp.data_ok), $sampled(acc_q));
        end

    a_data: assert property (@(posedge clk) disable iff (resetn)
        acc_q |-> (ibus_resp.data & mask_q) === (exp_q & mask_q))
        else begin
            errors++;
            $display("** Error: ibus_resp.data = %h, expected %h",
                     $sampled(ibus_resp.data) & $sampled(mask_q),
                     $sampled(exp_q) & $sampled(mask_q));
        end

    a_index: assert property (@(posedge clk) disable iff (resetn)
        acc_q |-> ibus_resp.index === half_q)
        else begin
            errors++;
            $display("** Error: ibus_resp.index = %h, expected %h",
                     $sampled(ibus_resp.index), $sampled(half_q));
        end

    // refills are reads of whole lines in eight beats
    a_cbus_req: assert property (@(posedge clk) disable iff (resetn)
        cbus_req.valid |-> (cbus_req.order == 3'd3 && !cbus_req.is_write))
        else begin
            errors++;
            $display("** Error: cbus_req.order = %h, cbus_req.is_write = %h, expected 3 and 0",
                     $sampled(cbus_req.order), $sampled(cbus_req.is_write));
        end

    // first cycle out of reset is idle on both buses
    a_reset_idle: assert property (@(posedge clk)
        (rst_q && !resetn) |-> (!ibus_resp.data_ok && !cbus_req.valid))
        else begin
            errors++;
            $display("** Error: data_ok = %h, cbus_req.valid = %h, expected 0 after reset",
                     $sampled(ibus_resp.data_ok), $sampled(cbus_req.valid));
        end

    task automatic require(input bit cond, input string what);
        assert (cond)
        else begin
            errors++;
            $display("check failed: %s", what);
        end
    endtask

    // holds req until addr_ok is seen mid cycle
    task automatic fetch(input logic [31:0] a, output int waits, output bit refill_seen,
                         output logic [31:0] refill_addr);
        bit got;
        waits       = 0;
        refill_seen = 0;
        refill_addr = '0;
        issued++;
        ibus_req.req  = 1'b1;
        ibus_req.addr = a;
        got = 0;
        while (!got) begin
            #50;
            got = ibus_resp.addr_ok;
            if (cbus_req.valid && !refill_seen) begin
                refill_seen = 1;
                refill_addr = cbus_req.addr;
            end
            @(posedge clk);
            #10;
            if (!got) begin
                waits++;
            end
        end
        ibus_req.req = 1'b0;
    endtask

    task automatic wait_refill_done();
        #50;
        while (cbus_req.valid) begin
            @(posedge clk);
            #60;
        end
        @(posedge clk);
        #10;
    endtask

    task automatic apply_reset();
        resetn = 1'b1;
        repeat (5) @(posedge clk);
        #10;
        resetn = 1'b0;
    endtask

    initial begin
        logic [31:0] a0;
        logic [31:0] b0;
        logic [31:0] t [9];
        logic [31:0] raddr;
        int          waits;
        bit          seen;
        a0 = 32'h0000_1008;
        b0 = 32'h0000_2010;
        for (int k = 0; k < 9; k++) begin
            t[k] = ((32'h100 + k) << 7) | 32'h20;
        end
        ibus_req = '0;
        resetn   = 1'b1;
        apply_reset();

        // cold miss with refill address and data
        fetch(a0, waits, seen, raddr);
        require(waits > 0, "first fetch did not miss");
        require(seen && raddr == {a0[31:2], 2'b00}, "refill address wrong or no refill");
        wait_refill_done();

        // back-to-back hits
        fetch(a0, waits, seen, raddr);
        require(waits == 0, "hit on a0 was not accepted at once");
        fetch(a0 + 32'h4, waits, seen, raddr);
        require(waits == 0, "hit on a0+4 was not accepted at once");
        fetch(a0 + 32'h10, waits, seen, raddr);
        require(waits == 0, "hit on a0+16 was not accepted at once");
        fetch(a0 - 32'h8, waits, seen, raddr);
        require(waits == 0, "hit on a0-8 was not accepted at once");

        // critical beat first while other lines keep hitting
        fetch(b0, waits, seen, raddr);
        require(waits > 0, "fetch of b0 did not miss");
        fetch(a0, waits, seen, raddr);
        require(waits == 0 && seen, "hit on other line not served during refill");
        fetch(b0 + 32'h4, waits, seen, raddr);
        fetch(b0 + 32'h8, waits, seen, raddr);
        fetch(b0 - 32'h10, waits, seen, raddr);
        fetch(b0 - 32'h4, waits, seen, raddr);
        wait_refill_done();

        // fill set 1 and touch every way before evicting the oldest
        for (int k = 0; k < 8; k++) begin
            fetch(t[k], waits, seen, raddr);
            require(waits > 0, "fill fetch did not miss");
            wait_refill_done();
        end
        for (int k = 0; k < 8; k++) begin
            fetch(t[k], waits, seen, raddr);
            require(waits == 0, "touch of a filled line missed");
        end
        fetch(t[8], waits, seen, raddr);
        require(waits > 0, "fetch of ninth tag did not miss");
        wait_refill_done();
        fetch(t[7], waits, seen, raddr);
        require(waits == 0, "most recent tag was evicted");
        fetch(t[0], waits, seen, raddr);
        require(waits > 0 && seen, "oldest tag was not the victim");

        // reset with a refill in flight
        apply_reset();
        fetch(a0, waits, seen, raddr);
        require(waits > 0, "cached line survived reset");
        wait_refill_done();
        repeat (3) @(posedge clk);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // 400 cycles of budget per fetch issued so far
    initial begin
        @(posedge clk);
        while (cycle <= 400 * (issued + 1)) begin
            @(posedge clk);
        end
        $display("timeout: no progress after %0d cycles", cycle);
        $display("errors: %0d", errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - logic
    files:
      - logic/icache_pkg.sv
      - logic/icache_plru.sv
      - logic/icache_data_ram.sv
      - logic/icache_tag_array.sv
      - logic/icache_refill.sv
      - logic/icache.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/tb_icache.sv

/* project.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache_plru.sv
logic/icache_data_ram.sv
logic/icache_tag_array.sv
logic/icache_refill.sv
logic/icache.sv
sim/mem_model.sv
sim/tb_icache.sv
